/* hw/dmem_pkg.sv */
//////////////////////////////////////////////////
// Data memory access package
// Shared widths, encodings and packed records for
// the request buffer, access checker and bus master
//////////////////////////////////////////////////

`default_nettype none

package dmem_pkg;

  //////////////////////////////////////////////////
  // Widths

  localparam int XLEN = 32;  // Data and address width

  //////////////////////////////////////////////////
  // Encodings

  // Access size as seen on CPU and bus
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  // Privilege level from the CSR state
  typedef enum logic [1:0] {
    PRV_U = 2'b00,  // User
    PRV_S = 2'b01,  // Supervisor
    PRV_M = 2'b11   // Machine
  } prv_e;

  // PMA region kind
  typedef enum logic [1:0] {
    PMA_EMPTY = 2'b00,  // Nothing mapped
    PMA_MEM   = 2'b01,  // Main memory
    PMA_IO    = 2'b10   // Peripheral space
  } pma_type_e;

  //////////////////////////////////////////////////
  // Records

  typedef struct packed {
    pma_type_e mem_type;
    logic      r;        // Readable
    logic      w;        // Writable
  } pma_cfg_t;

  // One buffered CPU access
  typedef struct packed {
    logic [XLEN-1:0] adr;
    mem_size_e       size;
    logic            lock;
    logic            we;
    logic [XLEN-1:0] data;
  } dmem_req_t;

  // Transfer held by the bus master
  typedef struct packed {
    logic [XLEN-1:0] adr;
    mem_size_e       size;
    logic            we;
    logic            lock;
    logic            priv;   // Privileged access
    logic [XLEN-1:0] data;
  } bus_req_t;

endpackage

`default_nettype wire

/* hw/dmem_req_buf.sv */
//////////////////////////////////////////////////
// Data memory request buffer
// In-order circular FIFO of accepted CPU accesses
// Head is presented to the checker, whole buffer
// is flushed on an exception
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dmem_req_buf
  import dmem_pkg::*;
#(
  parameter int BUF_DEPTH = 2
)
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  input  wire logic      clr_i,        // Drop all entries
  input  wire logic      push_i,
  input  wire dmem_req_t push_data_i,
  input  wire logic      pop_i,
  output logic           head_vld_o,
  output dmem_req_t      head_o
);

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  dmem_req_t          mem_q [BUF_DEPTH];  // Entry storage
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               full, push_ok, pop_ok;

  // Wrap pointer at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign full       = (cnt_q == CNT_W'(BUF_DEPTH));
  assign head_vld_o = (cnt_q != '0);
  assign head_o     = mem_q[rd_ptr_q];

  assign pop_ok  = pop_i & head_vld_o;               // Never pop empty
  assign push_ok = push_i & ~clr_i & (~full | pop_ok); // Clear beats push

  //////////////////////////////////////////////////
  // Pointers and fill level
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else if (clr_i)
    begin
      wr_ptr_q <= '0;  // Restart empty
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;        // Both or none keep level
      endcase
    end
  end

  // Payload store
  always_ff @(posedge clk_i)
  begin
    if (push_ok) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

/* hw/dmem_access_chk.sv */
//////////////////////////////////////////////////
// Data access checker
// Alignment test and top-of-range PMA lookup for
// the head access, purely combinational
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dmem_access_chk
  import dmem_pkg::*;
#(
  parameter int PMA_CNT = 4
)
(
  input  wire dmem_req_t       head_i,
  input  wire pma_cfg_t        pma_cfg_i [PMA_CNT],
  input  wire logic [XLEN-1:0] pma_adr_i [PMA_CNT],  // Region upper bounds
  output logic                 misaligned_o,
  output logic                 exception_o
);

  logic     hit;         // Some region matched
  pma_cfg_t hit_cfg;     // Attributes of the matching region
  logic     rd_fault, wr_fault, lock_fault, empty_fault;

  //////////////////////////////////////////////////
  // Alignment

  always_comb
  begin
    case (head_i.size)
      SIZE_HALF: misaligned_o = head_i.adr[0];     // Odd address
      SIZE_WORD: misaligned_o = |head_i.adr[1:0];  // Not word aligned
      default:   misaligned_o = 1'b0;              // Bytes always fit
    endcase
  end

  //////////////////////////////////////////////////
  // Region lookup

  // Region i spans from bound i-1 up to bound i
  always_comb
  begin : region_lookup
    logic [XLEN-1:0] lo_bound;
    lo_bound = '0;  // Region 0 starts at zero
    hit      = 1'b0;
    hit_cfg  = '0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      // First match is the lowest index
      if (!hit && head_i.adr >= lo_bound && head_i.adr < pma_adr_i[i])
      begin
        hit     = 1'b1;
        hit_cfg = pma_cfg_i[i];
      end
      lo_bound = pma_adr_i[i];  // Next region starts here
    end
  end

  //////////////////////////////////////////////////
  // Attribute faults

  assign empty_fault = (hit_cfg.mem_type == PMA_EMPTY);
  assign rd_fault    = ~head_i.we & ~hit_cfg.r;
  assign wr_fault    =  head_i.we & ~hit_cfg.w;
  assign lock_fault  =  head_i.lock & (hit_cfg.mem_type == PMA_IO);  // No atomics on io

  // Unmapped address or any attribute or alignment fault
  assign exception_o = ~hit
                     | empty_fault
                     | rd_fault
                     | wr_fault
                     | lock_fault
                     | misaligned_o;

endmodule

`default_nettype wire

/* hw/dmem_ext_if.sv */
//////////////////////////////////////////////////
// External bus master
// Drives one single transfer per issued access and
// returns the bus acknowledge, error and read data
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dmem_ext_if
  import dmem_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,

  // From control
  input  wire logic            issue_i,      // Start transfer for head
  input  wire dmem_req_t       issue_req_i,
  input  wire prv_e            prv_i,
  output logic                 busy_o,

  // Bus
  output logic                 biu_stb_o,
  input  wire logic            biu_stb_ack_i,
  output logic [XLEN-1:0]      biu_adri_o,
  output mem_size_e            biu_size_o,
  output logic                 biu_we_o,
  output logic                 biu_lock_o,
  output logic                 biu_prot_o,   // High for privileged
  output logic [XLEN-1:0]      biu_d_o,
  input  wire logic [XLEN-1:0] biu_q_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i,

  // Completion
  output logic                 done_ack_o,
  output logic                 done_err_o,
  output logic [XLEN-1:0]      done_q_o
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_ADR  = 2'b01,  // Strobe out, waiting for accept
    ST_DATA = 2'b10   // Waiting for ack or err
  } state_e;

  state_e   state_q;
  bus_req_t req_q;    // Latched transfer
  logic     data_end;

  assign data_end = (state_q == ST_DATA) & (biu_ack_i | biu_err_i);

  //////////////////////////////////////////////////
  // Transfer FSM

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      case (state_q)
        ST_IDLE: if (issue_i) state_q <= ST_ADR;
        ST_ADR:  if (biu_stb_ack_i) state_q <= ST_DATA;
        ST_DATA: if (data_end) state_q <= ST_IDLE;  // Ready for next head
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Capture request on issue
  always_ff @(posedge clk_i)
  begin
    if (issue_i && state_q == ST_IDLE)
    begin
      req_q.adr  <= issue_req_i.adr;
      req_q.size <= issue_req_i.size;
      req_q.we   <= issue_req_i.we;
      req_q.lock <= issue_req_i.lock;
      req_q.priv <= (prv_i != PRV_U);   // S and M are privileged
      req_q.data <= issue_req_i.data;
    end
  end

  //////////////////////////////////////////////////
  // Bus outputs

  assign busy_o     = (state_q != ST_IDLE);
  assign biu_stb_o  = (state_q == ST_ADR);  // Held until accepted
  assign biu_adri_o = req_q.adr;             // Steady for whole transfer
  assign biu_size_o = req_q.size;
  assign biu_we_o   = req_q.we;
  assign biu_lock_o = req_q.lock;
  assign biu_prot_o = req_q.priv;
  assign biu_d_o    = req_q.data;

  // Completion in the bus response cycle
  assign done_ack_o = (state_q == ST_DATA) & biu_ack_i;
  assign done_err_o = (state_q == ST_DATA) & biu_err_i;
  assign done_q_o   = biu_q_i;

endmodule

`default_nettype wire

/* hw/dmem_ctrl.sv */
//////////////////////////////////////////////////
// Data memory access block
// Buffers CPU loads and stores, checks alignment
// and PMA, issues legal accesses on the bus and
// returns acknowledge, read data or error
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dmem_ctrl
  import dmem_pkg::*;
#(
  parameter int PMA_CNT   = 4,
  parameter int BUF_DEPTH = 2
)
(
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,

  // Configuration
  input  wire pma_cfg_t        pma_cfg_i [PMA_CNT],
  input  wire logic [XLEN-1:0] pma_adr_i [PMA_CNT],
  input  wire prv_e            st_prv_i,

  // CPU side
  input  wire logic            mem_req_i,
  input  wire logic [XLEN-1:0] mem_adr_i,
  input  wire mem_size_e       mem_size_i,
  input  wire logic            mem_lock_i,
  input  wire logic            mem_we_i,
  input  wire logic [XLEN-1:0] mem_d_i,
  output logic [XLEN-1:0]      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,

  // Bus side
  output logic                 biu_stb_o,
  input  wire logic            biu_stb_ack_i,
  output logic [XLEN-1:0]      biu_adri_o,
  output mem_size_e            biu_size_o,
  output logic                 biu_we_o,
  output logic                 biu_lock_o,
  output logic                 biu_prot_o,
  output logic [XLEN-1:0]      biu_d_o,
  input  wire logic [XLEN-1:0] biu_q_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i
);

  dmem_req_t cpu_req, head;
  logic      head_vld;
  logic      misaligned, exception;
  logic      exc_resp;          // Faulty head answered now
  logic      issue, busy;
  logic      done_ack, done_err;

  // CPU access record
  assign cpu_req.adr  = mem_adr_i;
  assign cpu_req.size = mem_size_i;
  assign cpu_req.lock = mem_lock_i;
  assign cpu_req.we   = mem_we_i;
  assign cpu_req.data = mem_d_i;

  //////////////////////////////////////////////////
  // Datapath blocks

  dmem_req_buf #(
    .BUF_DEPTH ( BUF_DEPTH )
  ) u_req_buf (
    .clk_i       ( clk_i                ),
    .arst_n_i    ( arst_n_i             ),
    .clr_i       ( exc_resp             ),  // Drop head and followers
    .push_i      ( mem_req_i            ),
    .push_data_i ( cpu_req              ),
    .pop_i       ( done_ack | done_err  ),  // Bus completion
    .head_vld_o  ( head_vld             ),
    .head_o      ( head                 )
  );

  dmem_access_chk #(
    .PMA_CNT ( PMA_CNT )
  ) u_access_chk (
    .head_i       ( head       ),
    .pma_cfg_i    ( pma_cfg_i  ),
    .pma_adr_i    ( pma_adr_i  ),
    .misaligned_o ( misaligned ),
    .exception_o  ( exception  )
  );

  // Head decision
  assign exc_resp = head_vld & exception;
  assign issue    = head_vld & ~exception & ~busy;

  dmem_ext_if u_ext_if (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .issue_i       ( issue         ),
    .issue_req_i   ( head          ),
    .prv_i         ( st_prv_i      ),
    .busy_o        ( busy          ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_adri_o    ( biu_adri_o    ),
    .biu_size_o    ( biu_size_o    ),
    .biu_we_o      ( biu_we_o      ),
    .biu_lock_o    ( biu_lock_o    ),
    .biu_prot_o    ( biu_prot_o    ),
    .biu_d_o       ( biu_d_o       ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     ),
    .biu_err_i     ( biu_err_i     ),
    .done_ack_o    ( done_ack      ),
    .done_err_o    ( done_err      ),
    .done_q_o      ( mem_q_o       )
  );

  //////////////////////////////////////////////////
  // CPU responses

  assign mem_ack_o        = done_ack;
  assign mem_err_o        = exc_resp | done_err;  // Check fault or bus error
  assign mem_misaligned_o = exc_resp & misaligned;

endmodule

`default_nettype wire

/* tests/dmem_bus_model.sv */
//////////////////////////////////////////////////
// Behavioral bus slave
// Random wait states, read data from the address,
// error responses inside a fixed window
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dmem_bus_model
  import dmem_pkg::*;
#(
  parameter logic [XLEN-1:0] ERR_LO = 32'h0000_f000,  // Error window, inclusive
  parameter logic [XLEN-1:0] ERR_HI = 32'h0001_0000   // Error window, exclusive
)
(
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  input  wire logic            biu_stb_i,
  output logic                 biu_stb_ack_o,
  input  wire logic [XLEN-1:0] biu_adri_i,
  input  wire mem_size_e       biu_size_i,
  input  wire logic            biu_we_i,
  input  wire logic            biu_lock_i,
  input  wire logic            biu_prot_i,
  input  wire logic [XLEN-1:0] biu_d_i,
  output logic [XLEN-1:0]      biu_q_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o,
  output logic                 xfer_vld_o,  // One cycle per accepted strobe
  output bus_req_t             xfer_o       // Fields seen at acceptance
);

  logic [31:0] lfsr_q;
  bus_req_t    cur;     // Transfer in progress

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR bits give 0 to 3 wait cycles
  task automatic wait_random();
    int cycles;
    lfsr_q = lfsr_next(lfsr_q);
    cycles = int'(lfsr_q[0]);
    lfsr_q = lfsr_next(lfsr_q);
    cycles = cycles + 2 * int'(lfsr_q[0]);
    repeat (cycles) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Slave responses, driven on the falling edge

  initial
  begin
    lfsr_q        = 32'h1ea2b574;
    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_err_o     = 1'b0;
    biu_q_o       = '0;
    xfer_vld_o    = 1'b0;
    xfer_o        = '0;
    cur           = '0;
    forever
    begin
      @(negedge clk_i);
      if (arst_n_i && biu_stb_i)
      begin
        wait_random();                  // Address phase wait states
        cur = '{adr: biu_adri_i, size: biu_size_i, we: biu_we_i, lock: biu_lock_i,
                priv: biu_prot_i, data: biu_d_i};
        biu_stb_ack_o = 1'b1;
        xfer_vld_o    = 1'b1;
        xfer_o        = cur;            // Log for the checker
        @(negedge clk_i);
        biu_stb_ack_o = 1'b0;
        xfer_vld_o    = 1'b0;
        wait_random();                  // Data phase wait states
        if (cur.adr >= ERR_LO && cur.adr < ERR_HI)
        begin
          biu_err_o = 1'b1;
          biu_q_o   = '0;
        end
        else
        begin
          biu_ack_o = 1'b1;
          biu_q_o   = cur.adr ^ 32'hA5A5_0000;  // Read data from address
        end
        @(negedge clk_i);
        biu_ack_o = 1'b0;
        biu_err_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_dmem_ctrl.sv */
//////////////////////////////////////////////////
// Testbench for the data memory access block
// CPU loads and stores against a fixed PMA map,
// responses and bus transfers checked against a
// reference model
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_dmem_ctrl
  import dmem_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int PMA_CNT    = 4;
  localparam int BUF_DEPTH  = 2;
  localparam int ACCESS_CNT = 28;                         // Dropped ones included
  localparam logic [XLEN-1:0] ERR_LO   = 32'h0000_f000;   // Bus error window
  localparam logic [XLEN-1:0] ERR_HI   = 32'h0001_0000;
  localparam logic [XLEN-1:0] READ_XOR = 32'hA5A5_0000;

  // Expected outcome of one access
  typedef struct packed {
    logic            strobe;      // Reaches the bus
    logic            err;
    logic            misaligned;
    logic            chk_q;       // Read data compared
    logic [XLEN-1:0] q;
    bus_req_t        xfer;
  } expect_t;

  logic            clk_i = 1'b0;
  logic            arst_n_i;
  pma_cfg_t        pma_cfg_i [PMA_CNT];
  logic [XLEN-1:0] pma_adr_i [PMA_CNT];
  prv_e            st_prv_i;
  logic            mem_req_i, mem_lock_i, mem_we_i;
  logic [XLEN-1:0] mem_adr_i, mem_d_i, mem_q_o;
  mem_size_e       mem_size_i;
  logic            mem_ack_o, mem_err_o, mem_misaligned_o;
  logic            biu_stb_o, biu_stb_ack_i, biu_we_o, biu_lock_o, biu_prot_o;
  logic            biu_ack_i, biu_err_i;
  logic [XLEN-1:0] biu_adri_o, biu_d_o, biu_q_i;
  mem_size_e       biu_size_o;
  logic            xfer_vld;
  bus_req_t        xfer;

  expect_t  exp_resp_q [$];  // Responses still due
  bus_req_t exp_xfer_q [$];  // Transfers still due
  int       n_checks = 0;
  int       n_errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  dmem_ctrl #(
    .PMA_CNT   ( PMA_CNT   ),
    .BUF_DEPTH ( BUF_DEPTH )
  ) u_dmem_ctrl (.*);

  dmem_bus_model #(
    .ERR_LO ( ERR_LO ),
    .ERR_HI ( ERR_HI )
  ) u_bus_model (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .biu_stb_i     ( biu_stb_o     ),
    .biu_stb_ack_o ( biu_stb_ack_i ),
    .biu_adri_i    ( biu_adri_o    ),
    .biu_size_i    ( biu_size_o    ),
    .biu_we_i      ( biu_we_o      ),
    .biu_lock_i    ( biu_lock_o    ),
    .biu_prot_i    ( biu_prot_o    ),
    .biu_d_i       ( biu_d_o       ),
    .biu_q_o       ( biu_q_i       ),
    .biu_ack_o     ( biu_ack_i     ),
    .biu_err_o     ( biu_err_i     ),
    .xfer_vld_o    ( xfer_vld      ),
    .xfer_o        ( xfer          )
  );

  //////////////////////////////////////////////////
  // Reference model

  function automatic expect_t ref_access(input logic [XLEN-1:0] adr, input mem_size_e size,
                                         input logic we, input logic lock,
                                         input logic [XLEN-1:0] data, input prv_e prv);
    expect_t  e;
    pma_cfg_t cfg;
    logic     hit, fault;
    e   = '0;
    cfg = '0;
    hit = 1'b0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (!hit && adr < pma_adr_i[i])  // Bounds rise, first hit is lowest
      begin
        hit = 1'b1;
        cfg = pma_cfg_i[i];
      end
    end
    e.misaligned = (size == SIZE_HALF && adr[0]) || (size == SIZE_WORD && adr[1:0] != 2'b00);
    fault = !hit || cfg.mem_type == PMA_EMPTY || (we ? !cfg.w : !cfg.r)
            || (lock && cfg.mem_type == PMA_IO);
    e.strobe = !fault && !e.misaligned;
    e.err    = !e.strobe || (adr >= ERR_LO && adr < ERR_HI);  // Slave error window
    e.chk_q  = !e.err && !we;
    e.q      = adr ^ READ_XOR;
    e.xfer   = '{adr: adr, size: size, we: we, lock: lock, priv: prv != PRV_U, data: data};
    return e;
  endfunction

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    n_checks++;
    assert (got === exp)
    else
    begin
      n_errors++;
      $display("error: %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process, samples before the edge updates

  always @(posedge clk_i)
  begin : compare
    expect_t  e;
    bus_req_t x;
    if (arst_n_i && (mem_ack_o || mem_err_o || mem_misaligned_o))
    begin
      assert (exp_resp_q.size() != 0)
      else
      begin
        n_errors++;
        $display("Response at %0t ns with no access pending", $time);
      end
      if (exp_resp_q.size() != 0)
      begin
        e = exp_resp_q.pop_front();
        check_val("mem_ack_o", mem_ack_o, !e.err);
        check_val("mem_err_o", mem_err_o, e.err);
        check_val("mem_misaligned_o", mem_misaligned_o, e.misaligned);
        if (e.chk_q)
          check_val("mem_q_o", mem_q_o, e.q);
      end
    end
    if (arst_n_i && xfer_vld)
    begin
      assert (exp_xfer_q.size() != 0)
      else
      begin
        n_errors++;
        $display("Bus strobe at %0t ns with no legal access pending", $time);
      end
      if (exp_xfer_q.size() != 0)
      begin
        x = exp_xfer_q.pop_front();
        check_val("biu_adri_o", xfer.adr, x.adr);
        check_val("biu_size_o", xfer.size, x.size);
        check_val("biu_we_o", xfer.we, x.we);
        check_val("biu_lock_o", xfer.lock, x.lock);
        check_val("biu_prot_o", xfer.priv, x.priv);
        if (x.we)
          check_val("biu_d_o", xfer.data, x.data);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus, on the falling edge

  // One CPU request for one cycle, expected results queued when kept
  task automatic drive_req(input logic [XLEN-1:0] adr, input mem_size_e size, input logic we,
                           input logic lock, input logic [XLEN-1:0] data, input bit kept);
    expect_t e;
    e = ref_access(adr, size, we, lock, data, st_prv_i);
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_we_i   = we;
    mem_lock_i = lock;
    mem_d_i    = data;
    if (kept)
    begin
      exp_resp_q.push_back(e);
      if (e.strobe)
        exp_xfer_q.push_back(e.xfer);
    end
    @(negedge clk_i);
    mem_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_resp_q.size() != 0 || exp_xfer_q.size() != 0)
      @(negedge clk_i);
    repeat (3) @(negedge clk_i);  // Room for a stray response
  endtask

  task automatic run_access(input logic [XLEN-1:0] adr, input mem_size_e size, input logic we,
                            input logic lock, input logic [XLEN-1:0] data);
    drive_req(adr, size, we, lock, data, 1'b1);
    wait_idle();
  endtask

  initial
  begin : stimulus
    arst_n_i   = 1'b0;
    st_prv_i   = PRV_M;
    mem_req_i  = 1'b0;
    mem_adr_i  = '0;
    mem_size_i = SIZE_WORD;
    mem_we_i   = 1'b0;
    mem_lock_i = 1'b0;
    mem_d_i    = '0;
    pma_cfg_i[0] = '{PMA_MEM, 1'b1, 1'b1};
    pma_adr_i[0] = 32'h0001_0000;
    pma_cfg_i[1] = '{PMA_IO, 1'b1, 1'b1};
    pma_adr_i[1] = 32'h0002_0000;
    pma_cfg_i[2] = '{PMA_MEM, 1'b1, 1'b0};  // Read-only
    pma_adr_i[2] = 32'h0003_0000;
    pma_cfg_i[3] = '{PMA_EMPTY, 1'b0, 1'b0};
    pma_adr_i[3] = 32'h0004_0000;
    repeat (RST_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    check_val("biu_stb_o", biu_stb_o, 0);  // Idle after reset
    check_val("mem_ack_o", mem_ack_o, 0);
    check_val("mem_err_o", mem_err_o, 0);
    check_val("mem_misaligned_o", mem_misaligned_o, 0);
    @(negedge clk_i);
    // Aligned accesses, privilege varied
    run_access(32'h0000_0100, SIZE_WORD, 1'b1, 1'b0, 32'h1234_5678);
    run_access(32'h0000_0100, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    run_access(32'h0000_0202, SIZE_HALF, 1'b1, 1'b0, 32'h0000_beef);
    run_access(32'h0000_0206, SIZE_HALF, 1'b0, 1'b0, 32'h0);
    run_access(32'h0000_0303, SIZE_BYTE, 1'b1, 1'b0, 32'h0000_005a);
    run_access(32'h0000_0301, SIZE_BYTE, 1'b0, 1'b0, 32'h0);
    st_prv_i = PRV_U;
    run_access(32'h0001_0010, SIZE_WORD, 1'b1, 1'b0, 32'hcafe_f00d);
    run_access(32'h0001_0022, SIZE_HALF, 1'b0, 1'b0, 32'h0);
    run_access(32'h0001_0033, SIZE_BYTE, 1'b0, 1'b0, 32'h0);
    st_prv_i = PRV_S;
    run_access(32'h0000_0400, SIZE_WORD, 1'b0, 1'b1, 32'h0);  // Locked main memory
    run_access(32'h0002_0040, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    // Misaligned
    run_access(32'h0000_0101, SIZE_HALF, 1'b0, 1'b0, 32'h0);
    run_access(32'h0000_0102, SIZE_WORD, 1'b1, 1'b0, 32'h1111_2222);
    run_access(32'h0001_0001, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    // PMA faults
    run_access(32'h0002_0000, SIZE_WORD, 1'b1, 1'b0, 32'h3333_4444);
    run_access(32'h0003_0000, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    run_access(32'h0004_0000, SIZE_BYTE, 1'b0, 1'b0, 32'h0);
    run_access(32'hffff_fff0, SIZE_WORD, 1'b1, 1'b0, 32'h5555_6666);
    run_access(32'h0001_0004, SIZE_WORD, 1'b0, 1'b1, 32'h0);  // Locked io
    // Slave errors
    run_access(32'h0000_f000, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    run_access(32'h0000_f010, SIZE_HALF, 1'b1, 1'b0, 32'h0000_7777);
    // Back to back pairs
    drive_req(32'h0000_0500, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1);
    drive_req(32'h0000_0504, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1);
    wait_idle();
    drive_req(32'h0000_0600, SIZE_WORD, 1'b1, 1'b0, 32'h8888_9999, 1'b1);
    drive_req(32'h0001_0008, SIZE_BYTE, 1'b0, 1'b0, 32'h0, 1'b1);
    wait_idle();
    // Fault flushes the access right behind it
    drive_req(32'h0000_0701, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1);
    drive_req(32'h0000_0800, SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
    wait_idle();
    // Other address, so a leftover transfer of the dropped one shows up
    run_access(32'h0000_0904, SIZE_WORD, 1'b0, 1'b0, 32'h0);
    $display("Checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Budget of 20 cycles per access
  initial
  begin : watchdog
    #(CLK_PERIOD * (RST_CYCLES + ACCESS_CNT * 20));
    $display("Timeout, a response or bus transfer never arrived");
    $display("Checks %0d, errors %0d", n_checks, n_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/dmem_pkg.sv
hw/dmem_req_buf.sv
hw/dmem_access_chk.sv
hw/dmem_ext_if.sv
hw/dmem_ctrl.sv
tests/dmem_bus_model.sv
tests/tb_dmem_ctrl.sv

/* Makefile */
# Verilator simulation of the data memory access block

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dmem_ctrl
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# Build, run, then search the output for the pass message
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
